/* list.f */
+incdir+.
rv_pkg.sv
dec_exec_if.sv
exec_wb_if.sv
fetch_decode.sv
execute.sv
writeback.sv
rv_core.sv
tb_rv_core.sv

/* Bender.yml */
package:
  name: rv_core

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - rv_pkg.sv
      - dec_exec_if.sv
      - exec_wb_if.sv
      - fetch_decode.sv
      - execute.sv
      - writeback.sv
      - rv_core.sv
      - target: test
        files:
          - tb_rv_core.sv

/* tb_rv_core.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rv_defines.svh"

module tb_rv_core;
   localparam int PROG_MAX       = 32;
   localparam int N_RETIRE       = 22;   // trace length up to the third pass of the final jal
   localparam int TIMEOUT_CYCLES = 4 + PROG_MAX + 8 + N_RETIRE * 4 + 40;

   localparam logic [2:0] K_ADDI = 3'd0;
   localparam logic [2:0] K_ADD  = 3'd1;
   localparam logic [2:0] K_BEQ  = 3'd2;
   localparam logic [2:0] K_JAL  = 3'd3;
   localparam logic [2:0] K_BAD  = 3'd4;

   logic                              clk;
   logic                              rst;
   logic                              run;
   logic                              load_en;
   logic [$clog2(`RV_IMEM_DEPTH)-1:0] load_addr;
   logic [`RV_XLEN-1:0]               load_data;
   logic                              retire;
   logic [`RV_XLEN-1:0]               retire_pc;
   logic [4:0]                        retire_rd;
   logic [`RV_XLEN-1:0]               retire_value;
   logic                              retire_we;

   // ********************
   // program and expected trace
   // ********************
   logic [2:0]  p_kind [PROG_MAX];
   logic [4:0]  p_rd [PROG_MAX];
   logic [4:0]  p_rs1 [PROG_MAX];
   logic [4:0]  p_rs2 [PROG_MAX];
   logic [31:0] p_imm [PROG_MAX];
   logic [31:0] p_word [PROG_MAX];
   int          n_prog;

   logic [31:0] e_pc [N_RETIRE];
   logic [4:0]  e_rd [N_RETIRE];
   logic [31:0] e_value [N_RETIRE];
   logic        e_we [N_RETIRE];
   logic        e_chk [N_RETIRE];   // rd and value only mean something for writers

   logic [31:0] lcg_state;
   int          cyc;
   int          run_cyc;
   int          last_cyc;

   rv_core dut0 (
      .clk          (clk),
      .rst          (rst),
      .run          (run),
      .load_en      (load_en),
      .load_addr    (load_addr),
      .load_data    (load_data),
      .retire       (retire),
      .retire_pc    (retire_pc),
      .retire_rd    (retire_rd),
      .retire_value (retire_value),
      .retire_we    (retire_we)
   );

   always #10 clk = ~clk;

   always @(posedge clk) cyc <= cyc + 1;

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   function automatic logic [31:0] encode(input logic [2:0] kind, input logic [4:0] rd,
                                          input logic [4:0] rs1, input logic [4:0] rs2,
                                          input logic [31:0] imm);
      logic [31:0] w;
      case (kind)
         K_ADDI:  w = {imm[11:0], rs1, 3'b000, rd, 7'b0010011};
         K_ADD:   w = {7'b0, rs2, rs1, 3'b000, rd, 7'b0110011};
         K_BEQ:   w = {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], 7'b1100011};
         K_JAL:   w = {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
         default: w = 32'h0000_0073;   // ecall is not handled by the core
      endcase
      return w;
   endfunction

   task automatic add_instr(input logic [2:0] kind, input logic [4:0] rd, input logic [4:0] rs1,
                            input logic [4:0] rs2, input logic [31:0] imm);
      p_kind[n_prog] = kind;
      p_rd[n_prog]   = rd;
      p_rs1[n_prog]  = rs1;
      p_rs2[n_prog]  = rs2;
      p_imm[n_prog]  = imm;
      p_word[n_prog] = encode(kind, rd, rs1, rs2, imm);
      n_prog++;
   endtask

   task automatic build_program;
      logic [31:0] r;
      logic [31:0] ri;
      n_prog = 0;
      add_instr(K_ADDI, 1, 0, 0, 5);
      add_instr(K_ADDI, 2, 0, 0, -3);
      add_instr(K_ADD, 3, 1, 2, 0);
      add_instr(K_ADDI, 0, 1, 0, 7);   // write to x0 must not stick
      add_instr(K_ADD, 4, 0, 1, 0);
      for (int i = 0; i < 8; i++) begin
         lcg_state = lcg_next(lcg_state);
         r         = lcg_state;
         lcg_state = lcg_next(lcg_state);
         ri        = lcg_state;
         // sources and targets stay in x1..x4 which are all written above
         add_instr(r[31] ? K_ADD : K_ADDI, 5'd1 + r[29:28], 5'd1 + r[27:26],
                   5'd1 + r[25:24], {{20{ri[31]}}, ri[31:20]});
      end
      add_instr(K_BEQ, 0, 1, 1, 8);    // taken
      add_instr(K_ADDI, 5, 0, 0, 99);  // skipped
      add_instr(K_ADDI, 6, 0, 0, 1);
      add_instr(K_BEQ, 0, 6, 0, 8);    // not taken
      add_instr(K_JAL, 7, 0, 0, 8);
      add_instr(K_ADDI, 5, 0, 0, 55);  // skipped
      add_instr(K_ADD, 8, 7, 0, 0);    // reads the link register
      add_instr(K_BAD, 0, 0, 0, 0);
      add_instr(K_JAL, 0, 0, 0, 0);    // spin here
   endtask

   // ********************
   // reference model
   // ********************
   task automatic run_model;
      logic [31:0] regs [32];
      logic [31:0] pc;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] res;
      logic [31:0] next;
      logic        chk;
      int          idx;
      for (int r = 0; r < 32; r++) regs[r] = '0;
      pc = '0;
      for (int n = 0; n < N_RETIRE; n++) begin
         idx  = pc >> 2;
         a    = regs[p_rs1[idx]];
         b    = regs[p_rs2[idx]];
         res  = '0;
         chk  = 1'b0;
         next = pc + 4;
         case (p_kind[idx])
            K_ADDI: begin
               res = a + p_imm[idx];
               chk = 1'b1;
            end
            K_ADD: begin
               res = a + b;
               chk = 1'b1;
            end
            K_BEQ: if (a == b) next = pc + p_imm[idx];
            K_JAL: begin
               res  = pc + 4;
               next = pc + p_imm[idx];
               chk  = 1'b1;
            end
            default: ;
         endcase
         e_pc[n]    = pc;
         e_rd[n]    = chk ? p_rd[idx] : 5'd0;
         e_value[n] = res;
         e_we[n]    = chk && (p_rd[idx] != 5'd0);
         e_chk[n]   = chk;
         if (e_we[n]) regs[p_rd[idx]] = res;
         pc = next;
      end
   endtask

   task automatic halt_on_failure;
      $display("=== FAIL ===");
      $fatal(1, "stopped at the first error");
   endtask

   task automatic value_error(input string name, input logic [31:0] exp, input logic [31:0] got);
      $display("[ERROR] %0t ns %s expected 0x%08h got 0x%08h", $time, name, exp, got);
      halt_on_failure();
   endtask

   task automatic plain_error(input string msg);
      $display("[ERROR] %0t ns %s", $time, msg);
      halt_on_failure();
   endtask

   initial begin
      #(TIMEOUT_CYCLES * 20);
      $display("[ERROR] %0t ns no retire seen in time, the core seems stuck", $time);
      $display("=== FAIL ===");
      $fatal(1, "watchdog expired");
   end

   initial begin
      clk       = 1'b0;
      rst       = 1'b1;
      run       = 1'b0;
      load_en   = 1'b0;
      load_addr = '0;
      load_data = '0;
      cyc       = 0;
      lcg_state = 32'hc1bc344b;
      build_program();
      run_model();

      for (int i = 0; i < 4; i++) begin
         @(posedge clk);
         if (i > 0) assert (retire === 1'b0) else value_error("retire", 0, retire);
      end
      rst <= 1'b0;

      for (int i = 0; i < n_prog; i++) begin
         @(posedge clk);
         assert (retire === 1'b0) else value_error("retire", 0, retire);
         load_en   <= 1'b1;
         load_addr <= i[$clog2(`RV_IMEM_DEPTH)-1:0];
         load_data <= p_word[i];
      end
      @(posedge clk);
      load_en <= 1'b0;
      repeat (3) begin
         @(posedge clk);
         assert (retire === 1'b0) else value_error("retire", 0, retire);
      end
      @(posedge clk);
      run     <= 1'b1;
      run_cyc = cyc + 1;   // edge at which IDLE sees run

      for (int n = 0; n < N_RETIRE; n++) begin
         @(posedge clk);
         while (retire !== 1'b1) @(posedge clk);
         if (n == 0) begin
            assert (cyc == run_cyc + 5)
            else plain_error($sformatf("first retire came %0d cycles after run, not 5",
                                       cyc - run_cyc));
         end else begin
            assert (cyc - last_cyc == 4)
            else plain_error($sformatf("retire %0d came %0d cycles after the last, not 4",
                                       n, cyc - last_cyc));
         end
         last_cyc = cyc;
         assert (retire_pc === e_pc[n]) else value_error("retire_pc", e_pc[n], retire_pc);
         assert (retire_we === e_we[n]) else value_error("retire_we", e_we[n], retire_we);
         if (e_chk[n]) begin
            assert (retire_rd === e_rd[n]) else value_error("retire_rd", e_rd[n], retire_rd);
            assert (retire_value === e_value[n])
            else value_error("retire_value", e_value[n], retire_value);
         end
      end

      $display("=== PASS ===");
      $finish;
   end

endmodule

`default_nettype wire

/* rv_core.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rv_defines.svh"

module rv_core (
   input  wire                              clk,
   input  wire                              rst,
   input  wire                              run,
   input  wire                              load_en,
   input  wire [$clog2(`RV_IMEM_DEPTH)-1:0] load_addr,
   input  wire [`RV_XLEN-1:0]               load_data,
   output logic                             retire,
   output logic [`RV_XLEN-1:0]              retire_pc,
   output logic [$clog2(`RV_NREGS)-1:0]     retire_rd,
   output logic [`RV_XLEN-1:0]              retire_value,
   output logic                             retire_we
);
   localparam int RW = $clog2(`RV_NREGS);

   logic [RW-1:0]       rs1_addr;
   logic [RW-1:0]       rs2_addr;
   logic [`RV_XLEN-1:0] rs1_v;
   logic [`RV_XLEN-1:0] rs2_v;

   dec_exec_if dx ();
   exec_wb_if  xw ();

   fetch_decode u_fetch (
      .clk       (clk),
      .rst       (rst),
      .run       (run),
      .load_en   (load_en),
      .load_addr (load_addr),
      .load_data (load_data),
      .rs1_addr  (rs1_addr),
      .rs2_addr  (rs2_addr),
      .rs1_v     (rs1_v),
      .rs2_v     (rs2_v),
      .dx        (dx.source),
      .xw        (xw.sink)
   );

   execute u_exec (
      .clk (clk),
      .rst (rst),
      .dx  (dx.sink),
      .xw  (xw.source)
   );

   writeback u_wb (
      .clk           (clk),
      .rst           (rst),
      .rs1_addr      (rs1_addr),
      .rs2_addr      (rs2_addr),
      .rs1_v         (rs1_v),
      .rs2_v         (rs2_v),
      .xw            (xw.sink),
      .retire_pc     (dx.pc),
      .retire        (retire),
      .retire_pc_out (retire_pc),
      .retire_rd     (retire_rd),
      .retire_value  (retire_value),
      .retire_we     (retire_we)
   );

endmodule

`default_nettype wire

/* writeback.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rv_defines.svh"

module writeback (
   input  wire                          clk,
   input  wire                          rst,
   input  wire [$clog2(`RV_NREGS)-1:0]  rs1_addr,
   input  wire [$clog2(`RV_NREGS)-1:0]  rs2_addr,
   output logic [`RV_XLEN-1:0]          rs1_v,
   output logic [`RV_XLEN-1:0]          rs2_v,
   exec_wb_if.sink                      xw,
   input  wire [`RV_XLEN-1:0]           retire_pc,
   output logic                         retire,
   output logic [`RV_XLEN-1:0]          retire_pc_out,
   output logic [$clog2(`RV_NREGS)-1:0] retire_rd,
   output logic [`RV_XLEN-1:0]          retire_value,
   output logic                         retire_we
);

   logic [`RV_XLEN-1:0] regs [`RV_NREGS];
   logic                wr_en;

   // ********************
   // register file
   // ********************
   assign wr_en = xw.done && xw.reg_write_enabled && (xw.reg_write_dest != '0);

   always_ff @(posedge clk) begin
      if (wr_en) begin
         regs[xw.reg_write_dest] <= xw.result;
      end
   end

   assign rs1_v = (rs1_addr == '0) ? '0 : regs[rs1_addr];   // x0 reads zero
   assign rs2_v = (rs2_addr == '0) ? '0 : regs[rs2_addr];

   // ********************
   // retire report
   // ********************
   always_ff @(posedge clk) begin
      if (rst) begin
         retire    <= 1'b0;
         retire_we <= 1'b0;
      end else begin
         retire    <= xw.done;
         retire_we <= wr_en;
      end
   end

   always_ff @(posedge clk) begin
      if (xw.done) begin
         retire_pc_out <= retire_pc;   // pc still holds the current instruction in WRITE
         retire_rd     <= xw.reg_write_dest;
         retire_value  <= xw.result;
      end
   end

   a_retire_we: assert property (@(posedge clk) disable iff (rst)
      retire_we |-> retire && retire_rd != '0);

endmodule

`default_nettype wire

/* execute.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rv_defines.svh"

module execute (
   input  wire       clk,
   input  wire       rst,
   dec_exec_if.sink  dx,
   exec_wb_if.source xw
);
   localparam int XL = `RV_XLEN;

   logic          exec;
   logic          reg_we_n;
   logic          jump_n;
   logic [XL-1:0] result_n;

   assign exec = (dx.state == rv_pkg::EXEC);

   always_comb begin
      reg_we_n = 1'b0;
      jump_n   = 1'b0;
      result_n = '0;
      if (dx.ops.addi) begin
         reg_we_n = 1'b1;
         result_n = dx.rs1_v + dx.imm;
      end else if (dx.ops.add) begin
         reg_we_n = 1'b1;
         result_n = dx.rs1_v + dx.rs2_v;
      end else if (dx.ops.beq) begin
         jump_n = (dx.rs1_v == dx.rs2_v);
      end else if (dx.ops.jal) begin
         reg_we_n = 1'b1;
         result_n = dx.pc + XL'(4);   // link
         jump_n   = 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         xw.done              <= 1'b0;
         xw.reg_write_enabled <= 1'b0;
         xw.is_jump_enabled   <= 1'b0;
         xw.mem_write_enabled <= 1'b0;
      end else begin
         xw.done              <= exec;
         xw.reg_write_enabled <= exec && reg_we_n;
         xw.is_jump_enabled   <= exec && jump_n;
         xw.mem_write_enabled <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (exec) begin
         xw.result         <= result_n;
         xw.reg_write_dest <= dx.rd;
         xw.jump_dest      <= dx.pc + dx.imm;   // beq and jal share the target adder
      end
   end

   a_ops_onehot: assert property (@(posedge clk) disable iff (rst)
      exec |-> $onehot0(dx.ops));

   a_no_mem_write: assert property (@(posedge clk) disable iff (rst)
      !xw.mem_write_enabled);

   // x0 operands must arrive as zero from the register file
   a_x0_operand: assert property (@(posedge clk) disable iff (rst)
      exec |-> (dx.rs1 != '0 || dx.rs1_v == '0) && (dx.rs2 != '0 || dx.rs2_v == '0));

endmodule

`default_nettype wire

/* fetch_decode.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rv_defines.svh"

module fetch_decode (
   input  wire                              clk,
   input  wire                              rst,
   input  wire                              run,
   input  wire                              load_en,
   input  wire [$clog2(`RV_IMEM_DEPTH)-1:0] load_addr,
   input  wire [`RV_XLEN-1:0]               load_data,
   output logic [$clog2(`RV_NREGS)-1:0]     rs1_addr,
   output logic [$clog2(`RV_NREGS)-1:0]     rs2_addr,
   input  wire [`RV_XLEN-1:0]               rs1_v,
   input  wire [`RV_XLEN-1:0]               rs2_v,
   dec_exec_if.source                       dx,
   exec_wb_if.sink                          xw
);
   localparam int XL = `RV_XLEN;
   localparam int IW = $clog2(`RV_IMEM_DEPTH);
   localparam int RW = $clog2(`RV_NREGS);

   logic [XL-1:0]       imem [`RV_IMEM_DEPTH];
   rv_pkg::core_state_t state;
   logic [XL-1:0]       pc;
   rv_pkg::instr_word_t ir;
   rv_pkg::instr_ops_t  ops_d;
   logic [RW-1:0]       rd_d;
   logic [XL-1:0]       imm_d;

   always_ff @(posedge clk) begin
      if (load_en) begin
         imem[load_addr] <= load_data;   // only while stopped
      end
   end

   // ********************
   // sequencer and pc
   // ********************
   always_ff @(posedge clk) begin
      if (rst) begin
         state <= rv_pkg::IDLE;
      end else begin
         case (state)
            rv_pkg::IDLE:   if (run) state <= rv_pkg::FETCH;
            rv_pkg::FETCH:  state <= run ? rv_pkg::DECODE : rv_pkg::IDLE;
            rv_pkg::DECODE: state <= rv_pkg::EXEC;
            rv_pkg::EXEC:   state <= rv_pkg::WRITE;
            default:        state <= rv_pkg::FETCH;   // WRITE
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         pc <= '0;
      end else if (state == rv_pkg::WRITE) begin
         pc <= xw.is_jump_enabled ? xw.jump_dest : pc + XL'(4);
      end
   end

   always_ff @(posedge clk) begin
      if (state == rv_pkg::FETCH) begin
         ir <= imem[pc[IW+1:2]];   // word addressed
      end
   end

   // ********************
   // decode
   // ********************
   always_comb begin
      ops_d = '0;
      rd_d  = '0;
      imm_d = '0;
      case (ir.r_view.opcode)
         rv_pkg::OPC_OP_IMM: begin
            if (ir.i_view.funct3 == 3'b000) begin
               ops_d.addi = 1'b1;
               rd_d       = ir.i_view.rd;
               imm_d      = {{(XL-12){ir.i_view.imm[11]}}, ir.i_view.imm};
            end
         end
         rv_pkg::OPC_OP: begin
            if (ir.r_view.funct3 == 3'b000 && ir.r_view.funct7 == 7'b0) begin
               ops_d.add = 1'b1;
               rd_d      = ir.r_view.rd;
            end
         end
         rv_pkg::OPC_BRANCH: begin
            if (ir.b_view.funct3 == 3'b000) begin
               ops_d.beq = 1'b1;
               imm_d     = {{(XL-13){ir.b_view.imm_12}}, ir.b_view.imm_12, ir.b_view.imm_11,
                            ir.b_view.imm_10_5, ir.b_view.imm_4_1, 1'b0};
            end
         end
         rv_pkg::OPC_JAL: begin
            ops_d.jal = 1'b1;
            rd_d      = ir.j_view.rd;
            imm_d     = {{(XL-21){ir.j_view.imm_20}}, ir.j_view.imm_20, ir.j_view.imm_19_12,
                         ir.j_view.imm_11, ir.j_view.imm_10_1, 1'b0};
         end
         default: ;   // unsupported, no flag
      endcase
   end

   // register file read is combinational, value captured in DECODE
   assign rs1_addr = ir.r_view.rs1;
   assign rs2_addr = ir.r_view.rs2;

   always_ff @(posedge clk) begin
      if (state == rv_pkg::DECODE) begin
         dx.ops   <= ops_d;
         dx.rd    <= rd_d;
         dx.rs1   <= ir.r_view.rs1;
         dx.rs2   <= ir.r_view.rs2;
         dx.rs1_v <= rs1_v;
         dx.rs2_v <= rs2_v;
         dx.imm   <= imm_d;
      end
   end

   assign dx.state = state;
   assign dx.pc    = pc;

   a_state_legal: assert property (@(posedge clk) disable iff (rst)
      state inside {rv_pkg::IDLE, rv_pkg::FETCH, rv_pkg::DECODE, rv_pkg::EXEC, rv_pkg::WRITE});

   a_load_idle: assert property (@(posedge clk) disable iff (rst)
      load_en |-> state == rv_pkg::IDLE);

endmodule

`default_nettype wire

/* exec_wb_if.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rv_defines.svh"

interface exec_wb_if;
   localparam int RW = $clog2(`RV_NREGS);

   logic                done;               // high during WRITE
   logic [`RV_XLEN-1:0] result;
   logic                reg_write_enabled;
   logic [RW-1:0]       reg_write_dest;
   logic                mem_write_enabled;  // no data memory, stays low
   logic                is_jump_enabled;
   logic [`RV_XLEN-1:0] jump_dest;

   modport source (
      output done, result, reg_write_enabled, reg_write_dest,
      output mem_write_enabled, is_jump_enabled, jump_dest
   );

   // writeback and fetch both listen
   modport sink (
      input done, result, reg_write_enabled, reg_write_dest,
      input mem_write_enabled, is_jump_enabled, jump_dest
   );

endinterface

`default_nettype wire

/* dec_exec_if.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rv_defines.svh"

interface dec_exec_if;
   localparam int RW = $clog2(`RV_NREGS);

   rv_pkg::core_state_t state;
   logic [`RV_XLEN-1:0] pc;
   rv_pkg::instr_ops_t  ops;
   logic [RW-1:0]       rd;
   logic [RW-1:0]       rs1;     // source indices, for forwarding later on
   logic [RW-1:0]       rs2;
   logic [`RV_XLEN-1:0] rs1_v;
   logic [`RV_XLEN-1:0] rs2_v;
   logic [`RV_XLEN-1:0] imm;     // already sign extended

   modport source (
      output state, pc, ops, rd, rs1, rs2, rs1_v, rs2_v, imm
   );

   modport sink (
      input state, pc, ops, rd, rs1, rs2, rs1_v, rs2_v, imm
   );

endinterface

`default_nettype wire

/* rv_pkg.sv */
`default_nettype none

package rv_pkg;

   // ********************
   // opcodes
   // ********************
   localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
   localparam logic [6:0] OPC_OP     = 7'b0110011;
   localparam logic [6:0] OPC_BRANCH = 7'b1100011;
   localparam logic [6:0] OPC_JAL    = 7'b1101111;

   typedef enum logic [2:0] {
      IDLE   = 3'd0,
      FETCH  = 3'd1,
      DECODE = 3'd2,
      EXEC   = 3'd3,
      WRITE  = 3'd4
   } core_state_t;

   // all flags clear means unsupported
   typedef struct packed {
      logic addi;
      logic add;
      logic beq;
      logic jal;
   } instr_ops_t;

   // ********************
   // instruction formats
   // ********************
   typedef struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
   } r_fmt_t;

   typedef struct packed {
      logic [11:0] imm;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
   } i_fmt_t;

   typedef struct packed {
      logic       imm_12;
      logic [5:0] imm_10_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [3:0] imm_4_1;
      logic       imm_11;
      logic [6:0] opcode;
   } b_fmt_t;

   typedef struct packed {
      logic       imm_20;
      logic [9:0] imm_10_1;
      logic       imm_11;
      logic [7:0] imm_19_12;
      logic [4:0] rd;
      logic [6:0] opcode;
   } j_fmt_t;

   typedef union packed {
      r_fmt_t r_view;
      i_fmt_t i_view;
      b_fmt_t b_view;
      j_fmt_t j_view;
   } instr_word_t;

endpackage

`default_nettype wire

/* rv_defines.svh */
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// ********************
// core sizing
// ********************

// data path and address width
`define RV_XLEN 32

// instruction memory, in 32-bit words
`define RV_IMEM_DEPTH 64

`define RV_NREGS 32   // x0..x31

`endif
